// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
    -f vlog.f --top-module tb_triangle_top -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1
cat sim.log 2>/dev/null

grep -q "^PASS: all tests$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== src/bram_sdp.sv ====
/* simple dual-port ram
   one write port, one registered read port, zero at power-up */
`default_nettype none
`timescale 1ns/10ps

module bram_sdp #(
    parameter type data_t = logic [7:0],
    parameter int  DEPTH  = 256
) (
    input  wire logic clk_pix,
    input  wire logic we,
    input  wire logic [$clog2(DEPTH)-1:0] addr_write,
    input  wire logic [$clog2(DEPTH)-1:0] addr_read,
    input  wire data_t din,
    output data_t dout
);
    data_t mem [DEPTH] = '{default: '0};    // cleared at power-up

    always_ff @(posedge clk_pix) begin
        if (we) mem[addr_write] <= din;
        dout <= mem[addr_read];             // one cycle read latency
    end

    // caller keeps writes inside the array
    a_wr_addr: assert property (@(posedge clk_pix) we |-> addr_write < DEPTH);
endmodule

`default_nettype wire

// ==== src/display_timings.sv ====
/* display timings
   640x480 screen position counter with sync, data enable and frame start */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module display_timings (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    output raster_pkg::scr_coord_t sx,
    output raster_pkg::scr_coord_t sy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic frame_start
);
    import raster_pkg::*;

    localparam int HS_STA = `H_RES + `H_FP;     // first sync pixel
    localparam int HS_END = HS_STA + `H_SYNC;
    localparam int VS_STA = `V_RES + `V_FP;     // first sync line
    localparam int VS_END = VS_STA + `V_SYNC;

    scr_coord_t sx_nxt, sy_nxt;

    // next position, outputs decode from it so they stay aligned with sx/sy
    always_comb begin
        sx_nxt = (sx == `H_TOTAL-1) ? '0 : sx + 1'b1;
        sy_nxt = sy;
        if (sx == `H_TOTAL-1) sy_nxt = (sy == `V_TOTAL-1) ? '0 : sy + 1'b1;
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
            hsync <= 1'b1;          // inactive
            vsync <= 1'b1;
            de <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            sx <= sx_nxt;
            sy <= sy_nxt;
            hsync <= ~(sx_nxt >= HS_STA && sx_nxt < HS_END);
            vsync <= ~(sy_nxt >= VS_STA && sy_nxt < VS_END);
            de <= (sx_nxt < `H_RES) && (sy_nxt < `V_RES);
            frame_start <= (sx_nxt == 0) && (sy_nxt == `V_RES);  // vblank begins
        end
    end

    // line counter never runs past the blanking end
    a_sx_range: assert property (@(posedge clk_pix) disable iff (!arst_n)
        sx < `H_TOTAL);
endmodule

`default_nettype wire

// ==== src/draw_line.sv ====
/* line drawer
   integer error-term walk from (xa, ya) to (xb, yb), one pixel per enabled cycle */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module draw_line (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire logic line_start,
    input  wire logic enable,
    input  wire raster_pkg::coord_t xa,
    input  wire raster_pkg::coord_t ya,
    input  wire raster_pkg::coord_t xb,
    input  wire raster_pkg::coord_t yb,
    output raster_pkg::coord_t x,
    output raster_pkg::coord_t y,
    output logic valid,
    output logic busy,
    output logic done
);
    import raster_pkg::*;

    typedef enum logic {IDLE, DRAW} state_t;
    state_t state;

    coord_t xe, ye;                     // end point
    logic right, down;                  // step directions
    logic signed [9:0] dx, dy, err;     // dy kept negative
    logic signed [9:0] dx_in, dy_in;
    logic signed [10:0] e2;             // doubled error
    logic at_end;

    always_comb begin
        dx_in = (xa < xb) ? 10'(xb) - 10'(xa) : 10'(xa) - 10'(xb);
        dy_in = (ya < yb) ? 10'(ya) - 10'(yb) : 10'(yb) - 10'(ya);
        e2 = err <<< 1;
        at_end = (x == xe) && (y == ye);
        busy = (state == DRAW);
        valid = busy && enable;         // current x, y is a pixel
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                IDLE: if (line_start) state <= DRAW;
                DRAW: if (enable && at_end) begin
                    state <= IDLE;
                    done <= 1'b1;       // end point written this cycle
                end
                default: state <= IDLE;
            endcase
        end
    end

    // position and error term
    always_ff @(posedge clk_pix) begin
        if (state == IDLE && line_start) begin
            x <= xa;
            y <= ya;
            xe <= xb;
            ye <= yb;
            right <= xa < xb;
            down <= ya < yb;
            dx <= dx_in;
            dy <= dy_in;
            err <= dx_in + dy_in;
        end else if (valid && !at_end) begin
            if (e2 >= dy) x <= right ? x + 1'b1 : x - 1'b1;
            if (e2 <= dx) y <= down ? y + 1'b1 : y - 1'b1;
            err <= err + ((e2 >= dy) ? dy : 10'sd0) + ((e2 <= dx) ? dx : 10'sd0);
        end
    end

    a_x_range: assert property (@(posedge clk_pix) disable iff (!arst_n)
        busy |-> x < `FB_WIDTH);
endmodule

`default_nettype wire

// ==== src/draw_triangle.sv ====
/* triangle drawer
   latches a command and draws its three edges into the framebuffer */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module draw_triangle (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire logic draw_start,
    input  wire raster_pkg::coord_t x0,
    input  wire raster_pkg::coord_t y0,
    input  wire raster_pkg::coord_t x1,
    input  wire raster_pkg::coord_t y1,
    input  wire raster_pkg::coord_t x2,
    input  wire raster_pkg::coord_t y2,
    input  wire raster_pkg::cidx_t cidx,
    output logic draw_busy,
    output logic fb_we,
    output raster_pkg::fb_addr_t fb_addr,
    output raster_pkg::cidx_t fb_cidx
);
    import raster_pkg::*;

    coord_t vx [3];                 // latched vertices
    coord_t vy [3];
    cidx_t cidx_r;
    logic [1:0] edge_sel;           // edge being drawn
    logic [1:0] edge_end;           // vertex closing that edge
    logic line_start, line_valid, line_busy, line_done;
    coord_t px, py;

    always_comb edge_end = (edge_sel == 2'd2) ? 2'd0 : edge_sel + 2'd1;

    always_ff @(posedge clk_pix) begin
        if (draw_start && !draw_busy) begin
            vx <= '{x0, x1, x2};
            vy <= '{y0, y1, y2};
            cidx_r <= cidx;
        end
    end

    // edge sequencer, next edge starts on done
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            draw_busy <= 1'b0;
            edge_sel <= '0;
            line_start <= 1'b0;
        end else begin
            line_start <= 1'b0;
            if (!draw_busy) begin
                if (draw_start) begin   // starts while busy are dropped
                    draw_busy <= 1'b1;
                    edge_sel <= '0;
                    line_start <= 1'b1;
                end
            end else if (line_done) begin
                if (edge_sel == 2'd2) begin
                    draw_busy <= 1'b0;  // last pixel written on this edge
                end else begin
                    edge_sel <= edge_sel + 2'd1;
                    line_start <= 1'b1;
                end
            end
        end
    end

    draw_line u_line (
        .clk_pix,
        .arst_n,
        .line_start,
        .enable(1'b1),              // never stalls
        .xa(vx[edge_sel]),
        .ya(vy[edge_sel]),
        .xb(vx[edge_end]),
        .yb(vy[edge_end]),
        .x(px),
        .y(py),
        .valid(line_valid),
        .busy(line_busy),
        .done(line_done)
    );

    // address calc costs a cycle, so the write lags valid by one
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) fb_we <= 1'b0;
        else fb_we <= line_valid;
    end

    always_ff @(posedge clk_pix) begin
        fb_addr <= fb_addr_t'(py * `FB_WIDTH + px);
        fb_cidx <= cidx_r;
    end

    a_vert_range: assert property (@(posedge clk_pix) disable iff (!arst_n)
        draw_start && !draw_busy |-> x0 < `FB_WIDTH && x1 < `FB_WIDTH && x2 < `FB_WIDTH
            && y0 < `FB_HEIGHT && y1 < `FB_HEIGHT && y2 < `FB_HEIGHT);

    // the line drawer only runs inside a triangle command
    a_edge_in_cmd: assert property (@(posedge clk_pix) disable iff (!arst_n)
        line_busy |-> draw_busy);
endmodule

`default_nettype wire

// ==== src/linebuffer.sv ====
/* line buffer
   holds one framebuffer line and replays it LB_SCALE times in x and y */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module linebuffer (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire logic frame_start,
    input  wire logic de,
    input  wire logic en_in,
    input  wire raster_pkg::colr_t din,
    output logic line_req,
    output raster_pkg::colr_t dout
);
    import raster_pkg::*;

    localparam int AW = $clog2(`FB_WIDTH);
    localparam int SW = $clog2(`LB_SCALE);

    logic [AW-1:0] addr_in, addr_out;
    logic [SW-1:0] cnt_h, cnt_v;    // pixel and line repeats

    // write side
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) addr_in <= '0;
        else if (frame_start) addr_in <= '0;
        else if (en_in) addr_in <= (addr_in == `FB_WIDTH-1) ? '0 : addr_in + 1'b1;
    end

    // read side, stepped by de
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            addr_out <= '0;
            cnt_h <= '0;
            cnt_v <= '0;
            line_req <= 1'b0;
        end else begin
            line_req <= 1'b0;
            if (de) begin
                if (cnt_h == `LB_SCALE-1) begin
                    cnt_h <= '0;
                    if (addr_out == `FB_WIDTH-1) begin  // end of display line
                        addr_out <= '0;
                        if (cnt_v == `LB_SCALE-1) begin
                            cnt_v <= '0;
                            line_req <= 1'b1;   // next source line
                        end else begin
                            cnt_v <= cnt_v + 1'b1;
                        end
                    end else begin
                        addr_out <= addr_out + 1'b1;
                    end
                end else begin
                    cnt_h <= cnt_h + 1'b1;
                end
            end
            if (frame_start) begin      // first line of the next frame
                addr_out <= '0;
                cnt_h <= '0;
                cnt_v <= '0;
                line_req <= 1'b1;
            end
        end
    end

    bram_sdp #(
        .data_t(colr_t),
        .DEPTH(`FB_WIDTH)
    ) u_lb_mem (
        .clk_pix,
        .we(en_in),
        .addr_write(addr_in),
        .addr_read(addr_out),
        .din,
        .dout                           // one cycle after addr_out
    );
endmodule

`default_nettype wire

// ==== src/raster_defines.svh ====
/* raster defines
   framebuffer size, 640x480 display timing and line buffer scale */
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// framebuffer in pixels
`define FB_WIDTH  160
`define FB_HEIGHT 120

`define LB_SCALE  4     // display pixels per fb pixel in each direction

// horizontal timing in pixels
`define H_RES     640
`define H_FP      16    // front porch
`define H_SYNC    96
`define H_TOTAL   800   // includes back porch

// vertical timing in lines
`define V_RES     480
`define V_FP      10
`define V_SYNC    2
`define V_TOTAL   525

// both sync pulses are active low

`endif

// ==== src/raster_pkg.sv ====
/* raster package
   coordinate, address and colour types plus the fixed 4-entry palette */
`default_nettype none
`include "raster_defines.svh"

package raster_pkg;
    typedef logic [$clog2(`FB_WIDTH)-1:0] coord_t;       // fb coordinate
    typedef logic [$clog2(`H_TOTAL)-1:0] scr_coord_t;    // screen position
    typedef logic [$clog2(`FB_WIDTH*`FB_HEIGHT)-1:0] fb_addr_t;
    typedef logic [1:0] cidx_t;                          // colour index
    typedef logic [11:0] colr_t;                         // {r, g, b} 4 bits each

    // index to rgb
    localparam colr_t palette [4] = '{
        12'h000,    // black
        12'hf80,    // orange
        12'h0c4,    // green
        12'h28f     // blue
    };
endpackage

`default_nettype wire

// ==== src/scanout.sv ====
/* scanout
   streams framebuffer lines through the palette into the line buffer
   and realigns sync with the colour output */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module scanout (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire raster_pkg::scr_coord_t sy,
    input  wire logic hsync_in,
    input  wire logic vsync_in,
    input  wire logic de_in,
    input  wire logic frame_start,
    output raster_pkg::fb_addr_t fb_addr_read,
    input  wire raster_pkg::cidx_t fb_cidx,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);
    import raster_pkg::*;

    localparam int FB_PIXELS = `FB_WIDTH * `FB_HEIGHT;

    logic line_req;
    logic [$clog2(`FB_WIDTH+1)-1:0] cnt_rd;     // FB_WIDTH when idle
    logic [2:0] en_pipe;        // ram, palette reg, lb write stage
    cidx_t cidx_q;
    colr_t lb_din, lb_dout;

    // fb reader, one address per cycle per requested line
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            cnt_rd <= `FB_WIDTH;
            fb_addr_read <= '0;
        end else begin
            if (line_req && sy != `V_RES-1) begin   // none after the last line
                cnt_rd <= '0;
            end else if (cnt_rd < `FB_WIDTH) begin
                cnt_rd <= cnt_rd + 1'b1;
                fb_addr_read <= (fb_addr_read == FB_PIXELS-1) ? '0 : fb_addr_read + 1'b1;
            end
            if (frame_start) fb_addr_read <= '0;
        end
    end

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            en_pipe <= '0;
            hsync <= 1'b1;
            vsync <= 1'b1;
            de <= 1'b0;
        end else begin
            en_pipe <= {en_pipe[1:0], cnt_rd < `FB_WIDTH};
            hsync <= hsync_in;      // match lb read latency
            vsync <= vsync_in;
            de <= de_in;
        end
    end

    always_ff @(posedge clk_pix) begin
        cidx_q <= fb_cidx;          // ram output reg
        lb_din <= palette[cidx_q];
    end

    linebuffer u_lb (
        .clk_pix,
        .arst_n,
        .frame_start,
        .de(de_in),
        .en_in(en_pipe[2]),
        .din(lb_din),
        .line_req,
        .dout(lb_dout)
    );

    always_comb {red, green, blue} = de ? lb_dout : 12'h000;    // black in blanking
endmodule

`default_nettype wire

// ==== src/triangle_top.sv ====
/* triangle renderer top
   display timing, triangle drawer, framebuffer and scaled scanout */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module triangle_top (
    input  wire logic clk_pix,
    input  wire logic arst_n,
    input  wire raster_pkg::coord_t x0,
    input  wire raster_pkg::coord_t y0,
    input  wire raster_pkg::coord_t x1,
    input  wire raster_pkg::coord_t y1,
    input  wire raster_pkg::coord_t x2,
    input  wire raster_pkg::coord_t y2,
    input  wire raster_pkg::cidx_t cidx,
    input  wire logic draw_start,
    output logic draw_busy,
    output logic hsync,
    output logic vsync,
    output logic de,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);
    import raster_pkg::*;

    scr_coord_t sy;
    logic tm_hsync, tm_vsync, tm_de, frame_start;  // raw timing
    logic fb_we;
    fb_addr_t fb_addr_write, fb_addr_read;
    cidx_t fb_cidx_write, fb_cidx_read;

    display_timings u_timings (
        .clk_pix,
        .arst_n,
        .sx(),                      // column only used inside timing
        .sy,
        .hsync(tm_hsync),
        .vsync(tm_vsync),
        .de(tm_de),
        .frame_start
    );

    draw_triangle u_draw (
        .clk_pix,
        .arst_n,
        .draw_start,
        .x0,
        .y0,
        .x1,
        .y1,
        .x2,
        .y2,
        .cidx,
        .draw_busy,
        .fb_we,
        .fb_addr(fb_addr_write),
        .fb_cidx(fb_cidx_write)
    );

    bram_sdp #(
        .data_t(cidx_t),
        .DEPTH(`FB_WIDTH * `FB_HEIGHT)
    ) u_fb (
        .clk_pix,
        .we(fb_we),
        .addr_write(fb_addr_write),
        .addr_read(fb_addr_read),
        .din(fb_cidx_write),
        .dout(fb_cidx_read)
    );

    scanout u_scan (
        .clk_pix,
        .arst_n,
        .sy,
        .hsync_in(tm_hsync),
        .vsync_in(tm_vsync),
        .de_in(tm_de),
        .frame_start,
        .fb_addr_read,
        .fb_cidx(fb_cidx_read),
        .hsync,
        .vsync,
        .de,
        .red,
        .green,
        .blue
    );
endmodule

`default_nettype wire

// ==== verif/tb_raster_model.svh ====
/* raster reference model
   framebuffer copy, edge walk and expected screen colour */
`ifndef TB_RASTER_MODEL_SVH
`define TB_RASTER_MODEL_SVH

cidx_t ref_fb [`FB_HEIGHT][`FB_WIDTH] = '{default: '0};    // [y][x], blank at power-up

// one edge, both end points included
function automatic void trace_line(int xa, int ya, int xb, int yb, cidx_t c);
    int x, y, dx, dy, step_x, step_y, err, e2, guard;
    x = xa;
    y = ya;
    dx = (xb > xa) ? xb - xa : xa - xb;
    dy = (yb > ya) ? ya - yb : yb - ya;     // kept negative
    step_x = (xb > xa) ? 1 : -1;
    step_y = (yb > ya) ? 1 : -1;
    err = dx + dy;
    guard = 0;
    while (guard < 2 * `FB_WIDTH) begin     // no edge is longer than this
        ref_fb[y][x] = c;
        if (x == xb && y == yb) break;
        e2 = 2 * err;
        if (e2 >= dy) begin                 // x step
            err += dy;
            x += step_x;
        end
        if (e2 <= dx) begin                 // y step, same doubled value
            err += dx;
            y += step_y;
        end
        guard++;
    end
endfunction

// edge order v0-v1, v1-v2, v2-v0
function automatic void plot_triangle(int ax, int ay, int bx, int by,
                                      int cx, int cy, cidx_t c);
    trace_line(ax, ay, bx, by, c);
    trace_line(bx, by, cx, cy, c);
    trace_line(cx, cy, ax, ay, c);
endfunction

// screen pixel maps to cell (px/4, py/4)
function automatic colr_t expected_rgb(int px, int py);
    return palette[ref_fb[py / `LB_SCALE][px / `LB_SCALE]];
endfunction

`endif

// ==== verif/tb_triangle_top.sv ====
/* triangle renderer testbench
   random triangles against a reference model, checked on the scaled video output */
`default_nettype none
`timescale 1ns/10ps
`include "raster_defines.svh"

module tb_triangle_top;
    import raster_pkg::*;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    localparam int N_FRAMES = 11;           // worst case frames walked by the run
    localparam longint WATCHDOG_NS = N_FRAMES * 64'd3_500_000 + 64'd2_000_000;
    localparam int DRAW_LIMIT = 2000;       // cycle limit well above three full edges

    logic clk_pix = 1'b0;
    logic arst_n;
    coord_t x0, y0, x1, y1, x2, y2;
    cidx_t cidx;
    logic draw_start;
    logic draw_busy, hsync, vsync, de;
    logic [3:0] red, green, blue;

    `include "tb_raster_model.svh"

    triangle_top u_dut (
        .clk_pix, .arst_n,
        .x0, .y0, .x1, .y1, .x2, .y2,
        .cidx, .draw_start, .draw_busy,
        .hsync, .vsync, .de,
        .red, .green, .blue
    );

    always #4 clk_pix = ~clk_pix;           // 8 ns period

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1, "stopping at first error");
    endtask

    task automatic expect_int(input int got, input int exp, input string what);
        assert (got == exp) else
            fail_run($sformatf("MISMATCH at %0t: %s expected %0d got %0d",
                               $time, what, exp, got));
    endtask

    task automatic check_reset_state(input string when_s);
        expect_int(hsync, 1, {"hsync ", when_s});       // inactive high
        expect_int(vsync, 1, {"vsync ", when_s});
        expect_int(de, 0, {"de ", when_s});
        expect_int(draw_busy, 0, {"draw_busy ", when_s});
        expect_int({red, green, blue}, 0, {"colour ", when_s});
    endtask

    // returns on the negedge where vsync is first seen low
    task automatic wait_vsync_fall();
        int n;
        logic vs_q;
        @(negedge clk_pix);
        vs_q = vsync;
        for (n = 0; n < 2 * FRAME_CYCLES; n++) begin
            @(negedge clk_pix);
            if (vs_q && !vsync) return;
            vs_q = vsync;
        end
        fail_run("vsync never went low within two frame times");
    endtask

    // timing and colour of every cycle in one vsync-to-vsync frame
    task automatic check_frame(input string tag);
        int cyc, px, lines, de_rise, de_fall, hs_fall;
        logic de_q, hs_q, vs_q, line_de, done;
        colr_t got;
        wait_vsync_fall();
        cyc = 0;
        lines = 0;
        de_rise = 0;
        de_fall = 0;
        hs_fall = -1;                       // no hsync edge seen yet
        line_de = 1'b0;
        done = 1'b0;
        de_q = de;
        hs_q = hsync;
        vs_q = vsync;
        while (!done && cyc <= FRAME_CYCLES + `H_TOTAL) begin
            @(negedge clk_pix);
            cyc++;
            got = {red, green, blue};
            if (de) begin
                if (!de_q) de_rise = cyc;
                px = cyc - de_rise;
                expect_int(int'(px < `H_RES && lines < `V_RES), 1, {tag, " de inside 640x480"});
                assert (got == expected_rgb(px, lines)) else
                    fail_run($sformatf("MISMATCH at %0t: %s pixel (%0d,%0d) expected %h got %h",
                                       $time, tag, px, lines, expected_rgb(px, lines), got));
            end else begin
                expect_int(got, 0, {tag, " colour in blanking"});
            end
            if (de_q && !de) begin          // end of an active line
                expect_int(cyc - de_rise, `H_RES, {tag, " de high time"});
                de_fall = cyc;
                lines++;
                line_de = 1'b1;
            end
            if (hs_q && !hsync) begin
                if (hs_fall >= 0) expect_int(cyc - hs_fall, `H_TOTAL, {tag, " line period"});
                if (line_de) expect_int(cyc - de_fall, `H_FP, {tag, " horizontal front porch"});
                hs_fall = cyc;
                line_de = 1'b0;
            end
            if (!hs_q && hsync && hs_fall >= 0)
                expect_int(cyc - hs_fall, `H_SYNC, {tag, " hsync width"});
            if (!vs_q && vsync) expect_int(cyc, `V_SYNC * `H_TOTAL, {tag, " vsync width"});
            done = vs_q && !vsync;          // next frame's sync
            de_q = de;
            hs_q = hsync;
            vs_q = vsync;
        end
        expect_int(cyc, FRAME_CYCLES, {tag, " frame period"});
        expect_int(lines, `V_RES, {tag, " active lines"});
        expect_int(cyc - de_fall, (`H_TOTAL - `H_RES) + `V_FP * `H_TOTAL,
                   {tag, " vertical front porch"});
    endtask

    // one command plus optional stray starts while busy
    // returns when busy falls
    task automatic issue_triangle(input int ax, input int ay, input int bx, input int by,
                                  input int cx, input int cy, input cidx_t c,
                                  input int stray, output int n_ignored);
        int n;
        n_ignored = 0;
        @(posedge clk_pix);
        #1;
        expect_int(draw_busy, 0, "draw_busy before start");
        x0 = coord_t'(ax);
        y0 = coord_t'(ay);
        x1 = coord_t'(bx);
        y1 = coord_t'(by);
        x2 = coord_t'(cx);
        y2 = coord_t'(cy);
        cidx = c;
        draw_start = 1'b1;
        @(posedge clk_pix);
        #1;
        draw_start = 1'b0;
        expect_int(draw_busy, 1, "draw_busy after accepted start");
        plot_triangle(ax, ay, bx, by, cx, cy, c);
        for (n = 0; n < DRAW_LIMIT && draw_busy; n++) begin
            if (n < 2 * stray && n % 2 == 0) begin  // busy seen high so the DUT drops it
                x0 = coord_t'($urandom_range(`FB_WIDTH - 1, 0));
                y0 = coord_t'($urandom_range(`FB_HEIGHT - 1, 0));
                x1 = coord_t'($urandom_range(`FB_WIDTH - 1, 0));
                y1 = coord_t'($urandom_range(`FB_HEIGHT - 1, 0));
                cidx = cidx_t'($urandom_range(3, 1));
                draw_start = 1'b1;
                n_ignored++;
            end else begin
                draw_start = 1'b0;
            end
            @(posedge clk_pix);
            #1;
        end
        draw_start = 1'b0;
        if (draw_busy) fail_run("draw_busy stayed high past the drawing time limit");
    endtask

    task automatic random_triangle(input cidx_t c);
        int unused;
        issue_triangle($urandom_range(`FB_WIDTH - 1, 0), $urandom_range(`FB_HEIGHT - 1, 0),
                       $urandom_range(`FB_WIDTH - 1, 0), $urandom_range(`FB_HEIGHT - 1, 0),
                       $urandom_range(`FB_WIDTH - 1, 0), $urandom_range(`FB_HEIGHT - 1, 0),
                       c, 0, unused);
    endtask

    initial begin
        #(WATCHDOG_NS);
        fail_run("watchdog expired before the test sequence finished");
    end

    initial begin
        int a, b, k, i, n_ignored;
        void'($urandom(32'hecc6d83d));
        arst_n = 1'b0;
        draw_start = 1'b0;
        x0 = '0;
        y0 = '0;
        x1 = '0;
        y1 = '0;
        x2 = '0;
        y2 = '0;
        cidx = '0;
        repeat (2) begin
            @(negedge clk_pix);
            check_reset_state("during reset");
            @(posedge clk_pix);
        end
        #1 arst_n = 1'b1;
        @(negedge clk_pix);
        check_reset_state("after reset");

        check_frame("blank frame");         // timing plus all black

        random_triangle(cidx_t'($urandom_range(3, 1)));
        wait_vsync_fall();                  // frame may mix old and new lines
        check_frame("single triangle");

        a = $urandom_range(`FB_WIDTH - 1, 0);
        b = $urandom_range(`FB_HEIGHT - 1, 0);
        issue_triangle(a, b, a, b, a, b, cidx_t'($urandom_range(3, 1)), 0, n_ignored);
        a = $urandom_range(40, 0);
        b = $urandom_range(30, 0);
        k = $urandom_range(25, 1);
        issue_triangle(a, b, a + 2 * k, b + k, a + 4 * k, b + 2 * k,
                       cidx_t'($urandom_range(3, 0)), 0, n_ignored);    // slope 1/2
        for (i = 0; i < 10; i++) random_triangle(cidx_t'($urandom_range(3, 0)));
        wait_vsync_fall();
        check_frame("twelve triangles");

        // wide first edge keeps busy high through the stray starts
        issue_triangle($urandom_range(39, 0), $urandom_range(`FB_HEIGHT - 1, 0),
                       $urandom_range(`FB_WIDTH - 1, 120), $urandom_range(`FB_HEIGHT - 1, 0),
                       $urandom_range(`FB_WIDTH - 1, 0), $urandom_range(`FB_HEIGHT - 1, 0),
                       cidx_t'($urandom_range(3, 1)), 4, n_ignored);
        assert (n_ignored == 4) else
            fail_run("draw_busy fell before all stray start pulses were issued");
        wait_vsync_fall();
        check_frame("starts during busy");

        $display("PASS: all tests");
        $finish;
    end
endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+src
+incdir+verif
src/raster_pkg.sv
src/display_timings.sv
src/bram_sdp.sv
src/draw_line.sv
src/draw_triangle.sv
src/linebuffer.sv
src/scanout.sv
src/triangle_top.sv
verif/tb_triangle_top.sv
